/* build.f */
source/exu_pkg.sv
source/exu_alu.sv
source/exu_csr_file.sv
source/exu_lsu_mem.sv
source/exu_mem_timer.sv
source/exu_ctrl.sv
source/exu_resolve.sv
source/exu_top.sv
verif/exu_checker.sv
verif/exu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module exu_tb -f build.f -o exu_sim
./obj_dir/exu_sim > sim.log 2>&1 || true
cat sim.log
grep -q -F '*** PASSED ***' sim.log
echo "simulation passed"

/* verif/exu_tb.sv */
`timescale 1ns/1ns

module exu_tb import exu_pkg::*; ();

  logic        clk;
  logic        rst;
  logic        prev_valid_i;
  logic        next_ready_i;
  exu_opcode_e opcode_i;
  alu_op_e     alu_op_i;
  mem_op_e     mem_op_i;
  br_op_e      br_op_i;
  sys_op_e     sys_op_i;
  logic [31:0] op1_i;
  logic [31:0] op2_i;
  logic [31:0] imm_i;
  logic [31:0] pc_i;
  logic [11:0] csr_addr_i;
  logic        valid_o;
  logic        ready_o;
  logic [31:0] reg_wdata_o;
  logic [31:0] npc_o;

  integer      seed;
  integer      errors;
  logic [31:0] cur_pc;
  logic [7:0]  ref_mem [0:1023];
  logic [31:0] ref_mstatus;
  logic [31:0] ref_mtvec;
  logic [31:0] ref_mepc;
  logic [31:0] ref_mcause;

  exu_top #(.XLEN(32), .MEM_WORDS(256), .MEM_LATENCY(3)) UUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      alu_add:  return a + b;
      alu_sub:  return a - b;
      alu_and:  return a & b;
      alu_or:   return a | b;
      alu_xor:  return a ^ b;
      alu_sll:  return a << b[4:0];
      alu_srl:  return a >> b[4:0];
      alu_sra:  return $signed(a) >>> b[4:0];
      alu_slt:  return {31'b0, $signed(a) < $signed(b)};
      default:  return {31'b0, a < b};
    endcase
  endfunction

  function automatic logic branch_taken(br_op_e op, logic [31:0] a, logic [31:0] b);
    case (op)
      br_beq:  return a == b;
      br_bne:  return a != b;
      br_blt:  return $signed(a) < $signed(b);
      br_bge:  return $signed(a) >= $signed(b);
      br_bltu: return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic logic [31:0] load_ref(mem_op_e op, logic [9:0] a);
    logic [9:0] w;
    w = {a[9:2], 2'b00};
    case (op)
      mem_lb:  return {{24{ref_mem[a][7]}}, ref_mem[a]};
      mem_lbu: return {24'b0, ref_mem[a]};
      mem_lh:  return {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
      mem_lhu: return {16'b0, ref_mem[a+1], ref_mem[a]};
      default: return {ref_mem[w+3], ref_mem[w+2], ref_mem[w+1], ref_mem[w]};
    endcase
  endfunction

  function automatic logic [31:0] csr_read_ref(logic [11:0] addr);
    case (addr)
      CSR_MSTATUS: return ref_mstatus;
      CSR_MTVEC:   return ref_mtvec;
      CSR_MEPC:    return ref_mepc;
      CSR_MCAUSE:  return ref_mcause;
      default:     return 32'h0;
    endcase
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("timeout while waiting for %s at time %0t", what, $time);
    $display("errors: %0d, timeouts: 1", errors);
    $display("*** FAILED ***");
    $finish;
  endtask

  // one instruction in, waits for its result
  task automatic issue(input exu_opcode_e opc, input alu_op_e aop, input mem_op_e mop,
                       input br_op_e bop, input sys_op_e sop, input logic [31:0] a,
                       input logic [31:0] b, input logic [31:0] imm, input logic [11:0] ca);
    int n;
    n = 0;
    @(negedge clk);
    while (!ready_o && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (!ready_o) stop_on_timeout("ready_o");
    cur_pc = $random(seed) & 32'hfffffffc;
    @(posedge clk);
    opcode_i <= opc;
    alu_op_i <= aop;
    mem_op_i <= mop;
    br_op_i <= bop;
    sys_op_i <= sop;
    op1_i <= a;
    op2_i <= b;
    imm_i <= imm;
    pc_i <= cur_pc;
    csr_addr_i <= ca;
    prev_valid_i <= 1'b1;
    @(posedge clk);
    prev_valid_i <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!valid_o && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (!valid_o) stop_on_timeout("valid_o");
  endtask

  task automatic finish_instr(input logic [31:0] exp_w, input logic [31:0] exp_n,
                              input logic chk_w);
    int stall;
    assert (exp_n == npc_o) else begin
      $display("FAIL time %0t npc_o got %h expected %h", $time, npc_o, exp_n);
      errors++;
    end
    if (chk_w) begin
      assert (exp_w == reg_wdata_o) else begin
        $display("FAIL time %0t reg_wdata_o got %h expected %h", $time, reg_wdata_o, exp_w);
        errors++;
      end
    end
    stall = $unsigned($random(seed)) % 5;
    repeat (stall) @(posedge clk);
    @(posedge clk);
    next_ready_i <= 1'b1;
    @(posedge clk);
    next_ready_i <= 1'b0;
  endtask

  task automatic csr_op(input sys_op_e sop, input logic [11:0] addr, input logic [31:0] v);
    logic [31:0] old;
    logic [31:0] nv;
    old = csr_read_ref(addr);
    nv = (sop == sys_csrrw) ? v : (sop == sys_csrrs) ? (old | v) : (old & ~v);
    issue(op_system, alu_add, mem_lw, br_beq, sop, v, 32'h0, 32'h0, addr);
    finish_instr(old, cur_pc + 4, 1'b1);
    case (addr)
      CSR_MSTATUS: ref_mstatus = nv;
      CSR_MTVEC:   ref_mtvec = nv;
      CSR_MEPC:    ref_mepc = nv;
      default:     ref_mcause = nv;
    endcase
  endtask

  task automatic mem_store(input mem_op_e mop, input logic [31:0] base, input logic [1:0] lane,
                           input logic [31:0] d);
    logic [9:0] a;
    a = base[9:0] + 10'(lane);
    issue(op_store, alu_add, mop, br_beq, sys_csrrw, base, {30'b0, lane}, d, 12'h0);
    finish_instr(32'h0, cur_pc + 4, 1'b0);
    ref_mem[a] = d[7:0];
    if (mop != mem_sb) ref_mem[a+1] = d[15:8];
    if (mop == mem_sw) begin
      ref_mem[a+2] = d[23:16];
      ref_mem[a+3] = d[31:24];
    end
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] base;
    logic [1:0]  lane;
    alu_op_e     aop;
    mem_op_e     mop;
    seed = 32'h0271fcb4;
    errors = 0;
    rst = 1'b1;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b0;
    opcode_i = op_alu;
    alu_op_i = alu_add;
    mem_op_i = mem_lw;
    br_op_i = br_beq;
    sys_op_i = sys_csrrw;
    op1_i = '0;
    op2_i = '0;
    imm_i = '0;
    pc_i = '0;
    csr_addr_i = '0;
    ref_mstatus = '0;
    ref_mtvec = '0;
    ref_mepc = '0;
    ref_mcause = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    for (int k = 0; k < 10; k++) begin
      repeat (3) begin
        a = $random(seed);
        b = $random(seed);
        issue(op_alu, alu_op_e'(k), mem_lw, br_beq, sys_csrrw, a, b, 32'h0, 12'h0);
        finish_instr(alu_ref(alu_op_e'(k), a, b), cur_pc + 4, 1'b1);
      end
    end

    // beq/bne compare by sub, signed by slt, unsigned by sltu
    for (int k = 0; k < 6; k++) begin
      repeat (4) begin
        a = $random(seed);
        b = ($random(seed) & 1) ? a : $random(seed);
        imm = $random(seed) & 32'h00000ffc;
        aop = (k < 2) ? alu_sub : (k < 4) ? alu_slt : alu_sltu;
        issue(op_branch, aop, mem_lw, br_op_e'(k), sys_csrrw, a, b, imm, 12'h0);
        finish_instr(32'h0, branch_taken(br_op_e'(k), a, b) ? cur_pc + imm : cur_pc + 4,
                     1'b0);
      end
    end
    a = $random(seed);
    imm = $random(seed) & 32'h0000fffc;
    issue(op_jal, alu_add, mem_lw, br_beq, sys_csrrw, a, 32'h0, imm, 12'h0);
    finish_instr(cur_pc + 4, cur_pc + imm, 1'b1);
    issue(op_jalr, alu_add, mem_lw, br_beq, sys_csrrw, a, 32'h0, imm, 12'h0);
    finish_instr(cur_pc + 4, a + imm, 1'b1);

    repeat (6) begin
      base = ($random(seed) & 32'h000000ff) << 2;
      mem_store(mem_sw, base, 2'd0, $random(seed));
      mem_store(mem_sb, base, 2'($random(seed)), $random(seed));
      mem_store(mem_sh, base, 2'($random(seed) & 2), $random(seed));
      for (int k = 0; k < 5; k++) begin
        mop = mem_op_e'(k);
        lane = 2'($random(seed));
        if (mop == mem_lw) lane = 2'd0;
        if (mop == mem_lh || mop == mem_lhu) lane = lane & 2'd2;
        issue(op_load, alu_add, mop, br_beq, sys_csrrw, base, {30'b0, lane}, 32'h0, 12'h0);
        finish_instr(load_ref(mop, base[9:0] + 10'(lane)), cur_pc + 4, 1'b1);
      end
    end

    repeat (10) begin
      csr_op(sys_op_e'($unsigned($random(seed)) % 3), ($random(seed) & 1) ? CSR_MTVEC : CSR_MEPC,
             $random(seed));
    end
    csr_op(sys_csrrs, CSR_MTVEC, 32'h0);

    // trap entry and return
    csr_op(sys_csrrw, CSR_MTVEC, $random(seed) & 32'hfffffffc);
    issue(op_system, alu_add, mem_lw, br_beq, sys_ecall, 32'h0, 32'h0, 32'h0, 12'h0);
    finish_instr(32'h0, ref_mtvec, 1'b0);
    ref_mcause = 32'd11;
    ref_mepc = cur_pc;
    csr_op(sys_csrrs, CSR_MCAUSE, 32'h0);
    csr_op(sys_csrrs, CSR_MEPC, 32'h0);
    csr_op(sys_csrrw, CSR_MSTATUS, $random(seed));
    issue(op_system, alu_add, mem_lw, br_beq, sys_mret, 32'h0, 32'h0, 32'h0, 12'h0);
    finish_instr(32'h0, ref_mepc, 1'b0);
    ref_mstatus[MSTATUS_MIE] = ref_mstatus[MSTATUS_MPIE];
    ref_mstatus[MSTATUS_MPIE] = 1'b1;
    csr_op(sys_csrrs, CSR_MSTATUS, 32'h0);

    repeat (4) @(posedge clk);
    $display("errors: %0d, timeouts: 0", errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verif/exu_checker.sv */
`timescale 1ns/1ns

module exu_checker import exu_pkg::*; #(
  parameter int XLEN        = 32,
  parameter int MEM_LATENCY = 3
) (
  input logic            clk,
  input logic            rst,
  input logic            prev_valid_i,
  input logic            next_ready_i,
  input logic            valid_o,
  input logic            ready_o,
  input exu_opcode_e     opcode_i,
  input logic [XLEN-1:0] reg_wdata_o,
  input logic [XLEN-1:0] npc_o
);

  logic accept;
  logic is_mem;

  assign accept = prev_valid_i && ready_o;
  assign is_mem = (opcode_i == op_load) || (opcode_i == op_store);

  a_excl: assert property (@(posedge clk) !(valid_o && ready_o))
    else $error("valid_o and ready_o high together");

  // back-pressure keeps the result in place
  a_hold: assert property (@(posedge clk) disable iff (rst)
    valid_o && !next_ready_i |=> valid_o && $stable(reg_wdata_o) && $stable(npc_o))
    else $error("result changed while next_ready_i was low");

  a_fast: assert property (@(posedge clk) disable iff (rst)
    accept && !is_mem |=> valid_o)
    else $error("valid_o late after a non-memory instruction");

  a_mem_early: assert property (@(posedge clk) disable iff (rst)
    accept && is_mem |=> !valid_o ##(MEM_LATENCY-1) !valid_o)
    else $error("valid_o early after a memory instruction");

  a_mem_late: assert property (@(posedge clk) disable iff (rst)
    accept && is_mem |-> ##(MEM_LATENCY+1) valid_o)
    else $error("valid_o missing after the memory wait");

  a_reset: assert property (@(posedge clk) rst |=> !valid_o && ready_o)
    else $error("handshake not idle after reset");

endmodule

bind exu_top exu_checker #(.XLEN(XLEN), .MEM_LATENCY(MEM_LATENCY)) u_checker (
  .clk(clk), .rst(rst), .prev_valid_i(prev_valid_i), .next_ready_i(next_ready_i),
  .valid_o(valid_o), .ready_o(ready_o), .opcode_i(opcode_i),
  .reg_wdata_o(reg_wdata_o), .npc_o(npc_o)
);

/* source/exu_top.sv */
`timescale 1ns/1ns

module exu_top import exu_pkg::*; #(
  parameter int XLEN        = 32,
  parameter int MEM_WORDS   = 256,
  parameter int MEM_LATENCY = 3
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            prev_valid_i,
  input  logic            next_ready_i,
  output logic            valid_o,
  output logic            ready_o,
  input  exu_opcode_e     opcode_i,
  input  alu_op_e         alu_op_i,
  input  mem_op_e         mem_op_i,
  input  br_op_e          br_op_i,
  input  sys_op_e         sys_op_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] op2_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [11:0]     csr_addr_i,
  output logic [XLEN-1:0] reg_wdata_o,
  output logic [XLEN-1:0] npc_o
);

  logic            timer_start;
  logic            timer_done;
  logic            mem_strobe;
  logic            commit;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] csr_rdata;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mtvec;
  logic            csr_wen;
  logic [XLEN-1:0] csr_wdata;
  logic            ecall;
  logic            mret;

  exu_ctrl u_ctrl (
    .clk(clk), .rst(rst),
    .prev_valid_i(prev_valid_i), .next_ready_i(next_ready_i),
    .opcode_i(opcode_i), .timer_done_i(timer_done),
    .ready_o(ready_o), .valid_o(valid_o),
    .timer_start_o(timer_start), .mem_strobe_o(mem_strobe), .commit_o(commit)
  );

  exu_mem_timer #(.MEM_LATENCY(MEM_LATENCY)) u_timer (
    .clk(clk), .rst(rst), .start_i(timer_start), .done_o(timer_done)
  );

  exu_alu #(.XLEN(XLEN)) u_alu (
    .a_i(op1_i), .b_i(op2_i), .alu_op_i(alu_op_i), .res_o(alu_res)
  );

  // op1+op2 forms the address, so store data rides on imm_i
  exu_lsu_mem #(.XLEN(XLEN), .MEM_WORDS(MEM_WORDS)) u_mem (
    .clk(clk), .strobe_i(mem_strobe), .opcode_i(opcode_i), .mem_op_i(mem_op_i),
    .addr_i(alu_res), .wdata_i(imm_i), .rdata_o(load_data)
  );

  exu_csr_file #(.XLEN(XLEN)) u_csr (
    .clk(clk), .rst(rst), .commit_i(commit),
    .csr_wen_i(csr_wen), .csr_addr_i(csr_addr_i), .csr_wdata_i(csr_wdata),
    .ecall_i(ecall), .mret_i(mret), .pc_i(pc_i),
    .csr_rdata_o(csr_rdata), .mepc_o(mepc), .mtvec_o(mtvec)
  );

  exu_resolve #(.XLEN(XLEN)) u_resolve (
    .opcode_i(opcode_i), .br_op_i(br_op_i), .sys_op_i(sys_op_i),
    .op1_i(op1_i), .imm_i(imm_i), .pc_i(pc_i),
    .alu_res_i(alu_res), .load_data_i(load_data), .csr_rdata_i(csr_rdata),
    .mepc_i(mepc), .mtvec_i(mtvec),
    .reg_wdata_o(reg_wdata_o), .npc_o(npc_o),
    .csr_wen_o(csr_wen), .csr_wdata_o(csr_wdata), .ecall_o(ecall), .mret_o(mret)
  );

endmodule

/* source/exu_resolve.sv */
`timescale 1ns/1ns

module exu_resolve import exu_pkg::*; #(
  parameter int XLEN = 32
) (
  input  exu_opcode_e     opcode_i,
  input  br_op_e          br_op_i,
  input  sys_op_e         sys_op_i,
  input  logic [XLEN-1:0] op1_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] alu_res_i,
  input  logic [XLEN-1:0] load_data_i,
  input  logic [XLEN-1:0] csr_rdata_i,
  input  logic [XLEN-1:0] mepc_i,
  input  logic [XLEN-1:0] mtvec_i,
  output logic [XLEN-1:0] reg_wdata_o,
  output logic [XLEN-1:0] npc_o,
  output logic            csr_wen_o,
  output logic [XLEN-1:0] csr_wdata_o,
  output logic            ecall_o,
  output logic            mret_o
);

  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] target;
  logic            is_sys;
  logic            taken;

  assign pc_plus4 = pc_i + XLEN'(4);
  assign target   = ((opcode_i == op_jalr) ? op1_i : pc_i) + imm_i;
  assign is_sys   = (opcode_i == op_system);

  // beq/bge/bgeu take on a zero compare result
  always_comb begin
    case (br_op_i)
      br_beq, br_bge, br_bgeu: taken = ~|alu_res_i;
      default:                 taken = |alu_res_i;
    endcase
  end

  assign ecall_o   = is_sys && (sys_op_i == sys_ecall);
  assign mret_o    = is_sys && (sys_op_i == sys_mret);
  assign csr_wen_o = is_sys && (sys_op_i inside {sys_csrrw, sys_csrrs, sys_csrrc});

  always_comb begin
    csr_wdata_o = '0;
    case (sys_op_i)
      sys_csrrw: csr_wdata_o = op1_i;
      sys_csrrs: csr_wdata_o = csr_rdata_i | op1_i;
      sys_csrrc: csr_wdata_o = csr_rdata_i & ~op1_i;
      sys_mret: begin
        csr_wdata_o = csr_rdata_i;
        csr_wdata_o[MSTATUS_MIE]  = csr_rdata_i[MSTATUS_MPIE];
        csr_wdata_o[MSTATUS_MPIE] = 1'b1;
      end
      default: ;
    endcase
  end

  always_comb begin
    npc_o       = pc_plus4;
    reg_wdata_o = alu_res_i;
    case (opcode_i)
      op_load:   reg_wdata_o = load_data_i;
      op_branch: if (taken) npc_o = target;
      op_jal, op_jalr: begin
        npc_o       = target;
        reg_wdata_o = pc_plus4;
      end
      op_system: begin
        reg_wdata_o = csr_rdata_i;
        if (ecall_o) npc_o = mtvec_i;
        if (mret_o) npc_o = mepc_i;
      end
      default: ;
    endcase
  end

endmodule

/* source/exu_ctrl.sv */
`timescale 1ns/1ns

module exu_ctrl import exu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        prev_valid_i,
  input  logic        next_ready_i,
  input  exu_opcode_e opcode_i,
  input  logic        timer_done_i,
  output logic        ready_o,
  output logic        valid_o,
  output logic        timer_start_o,
  output logic        mem_strobe_o,
  output logic        commit_o
);

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  logic        is_mem;
  logic        accept;

  assign is_mem = (opcode_i == op_load) || (opcode_i == op_store);
  assign accept = prev_valid_i && ready_o;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:     if (prev_valid_i) state_nxt = is_mem ? st_mem_wait : st_done;
      st_mem_wait: if (timer_done_i) state_nxt = st_done;
      st_done:     if (next_ready_i) state_nxt = st_idle;
      default:     state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  assign ready_o       = (state == st_idle);
  assign valid_o       = (state == st_done);
  assign timer_start_o = accept && is_mem;
  // memory access lands on the same edge that leaves the wait state
  assign mem_strobe_o  = (state == st_mem_wait) && timer_done_i;
  assign commit_o      = valid_o && next_ready_i;

endmodule

/* source/exu_mem_timer.sv */
`timescale 1ns/1ns

module exu_mem_timer #(
  parameter int MEM_LATENCY = 3
) (
  input  logic clk,
  input  logic rst,
  input  logic start_i,
  output logic done_o
);

  localparam int CW = $clog2(MEM_LATENCY + 1);

  logic [CW-1:0] cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (start_i) begin
      cnt <= CW'(MEM_LATENCY);
    end else if (cnt != '0) begin
      cnt <= cnt - CW'(1);
    end
  end

  // high for the last cycle of the count
  assign done_o = (cnt == CW'(1));

endmodule

/* source/exu_lsu_mem.sv */
`timescale 1ns/1ns

module exu_lsu_mem import exu_pkg::*; #(
  parameter int XLEN      = 32,
  parameter int MEM_WORDS = 256
) (
  input  logic            clk,
  input  logic            strobe_i,
  input  exu_opcode_e     opcode_i,
  input  mem_op_e         mem_op_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  output logic [XLEN-1:0] rdata_o
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [AW-1:0]   word_idx;
  logic [1:0]      lane;
  logic [XLEN-1:0] word;
  logic [7:0]      byte_sel;
  logic [15:0]     half_sel;
  logic [XLEN-1:0] load_val;

  assign word_idx = addr_i[AW+1:2];
  assign lane     = addr_i[1:0];
  assign word     = mem[word_idx];
  assign byte_sel = word[{lane, 3'b000} +: 8];
  // halves sit on lane 0 or lane 2
  assign half_sel = word[{lane[1], 4'b0000} +: 16];

  always_comb begin
    case (mem_op_i)
      mem_lb:  load_val = {{(XLEN-8){byte_sel[7]}}, byte_sel};
      mem_lbu: load_val = {{(XLEN-8){1'b0}}, byte_sel};
      mem_lh:  load_val = {{(XLEN-16){half_sel[15]}}, half_sel};
      mem_lhu: load_val = {{(XLEN-16){1'b0}}, half_sel};
      mem_lw:  load_val = word;
      default: load_val = word;
    endcase
  end

  always_ff @(posedge clk) begin
    if (strobe_i) begin
      if (opcode_i == op_store) begin
        case (mem_op_i)
          mem_sb:  mem[word_idx][{lane, 3'b000} +: 8]     <= wdata_i[7:0];
          mem_sh:  mem[word_idx][{lane[1], 4'b0000} +: 16] <= wdata_i[15:0];
          mem_sw:  mem[word_idx]                          <= wdata_i;
          default: ;
        endcase
      end else if (opcode_i == op_load) begin
        // held until the next load
        rdata_o <= load_val;
      end
    end
  end

endmodule

/* source/exu_csr_file.sv */
`timescale 1ns/1ns

module exu_csr_file import exu_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            commit_i,
  input  logic            csr_wen_i,
  input  logic [11:0]     csr_addr_i,
  input  logic [XLEN-1:0] csr_wdata_i,
  input  logic            ecall_i,
  input  logic            mret_i,
  input  logic [XLEN-1:0] pc_i,
  output logic [XLEN-1:0] csr_rdata_o,
  output logic [XLEN-1:0] mepc_o,
  output logic [XLEN-1:0] mtvec_o
);

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  // mret always works on mstatus, whatever the address field holds
  always_comb begin
    if (mret_i) begin
      csr_rdata_o = mstatus;
    end else begin
      case (csr_addr_i)
        CSR_MSTATUS: csr_rdata_o = mstatus;
        CSR_MTVEC:   csr_rdata_o = mtvec;
        CSR_MEPC:    csr_rdata_o = mepc;
        CSR_MCAUSE:  csr_rdata_o = mcause;
        default:     csr_rdata_o = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (commit_i) begin
      if (csr_wen_i) begin
        case (csr_addr_i)
          CSR_MSTATUS: mstatus <= csr_wdata_i;
          CSR_MTVEC:   mtvec   <= csr_wdata_i;
          CSR_MEPC:    mepc    <= csr_wdata_i;
          CSR_MCAUSE:  mcause  <= csr_wdata_i;
          default: ;
        endcase
      end
      if (ecall_i) begin
        mcause <= XLEN'(CAUSE_ECALL_M);
        mepc   <= pc_i;
      end
      if (mret_i) begin
        mstatus <= csr_wdata_i;
      end
    end
  end

  assign mepc_o  = mepc;
  assign mtvec_o = mtvec;

endmodule

/* source/exu_alu.sv */
`timescale 1ns/1ns

module exu_alu import exu_pkg::*; #(
  parameter int XLEN = 32
) (
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  input  alu_op_e         alu_op_i,
  output logic [XLEN-1:0] res_o
);

  localparam int SW = $clog2(XLEN);

  logic [SW-1:0] shamt;

  assign shamt = b_i[SW-1:0];

  always_comb begin
    case (alu_op_i)
      alu_add:  res_o = a_i + b_i;
      alu_sub:  res_o = a_i - b_i;
      alu_and:  res_o = a_i & b_i;
      alu_or:   res_o = a_i | b_i;
      alu_xor:  res_o = a_i ^ b_i;
      alu_sll:  res_o = a_i << shamt;
      alu_srl:  res_o = a_i >> shamt;
      alu_sra:  res_o = $signed(a_i) >>> shamt;
      // compares give 0 or 1, branches test for nonzero
      alu_slt:  res_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      alu_sltu: res_o = {{(XLEN-1){1'b0}}, a_i < b_i};
      default:  res_o = '0;
    endcase
  end

endmodule

/* source/exu_pkg.sv */
package exu_pkg;

  typedef enum logic [2:0] {
    op_alu,
    op_load,
    op_store,
    op_branch,
    op_jal,
    op_jalr,
    op_system
  } exu_opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
  } alu_op_e;

  typedef enum logic [2:0] {
    mem_lb, mem_lh, mem_lw, mem_lbu, mem_lhu,
    mem_sb, mem_sh, mem_sw
  } mem_op_e;

  typedef enum logic [2:0] {
    br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu
  } br_op_e;

  typedef enum logic [2:0] {
    sys_csrrw, sys_csrrs, sys_csrrc, sys_ecall, sys_mret
  } sys_op_e;

  typedef enum logic [1:0] {
    st_idle,
    st_mem_wait,
    st_done
  } ctrl_state_e;

  // machine csr addresses
  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam int MSTATUS_MIE   = 3;
  localparam int MSTATUS_MPIE  = 7;
  localparam int CAUSE_ECALL_M = 11;

endpackage
